//--- hw/core_regs_pkg.sv
////////////////////////////////////////
// Global settings addresses and readback codes
// Settings bus is 8-bit address, 32-bit data
////////////////////////////////////////
package core_regs_pkg;

  // Settings bus geometry
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;

  // Global settings addresses
  localparam logic [7:0] SR_CORE_READBACK = 8'd0;
  localparam logic [7:0] SR_CORE_MISC     = 8'd4;
  localparam logic [7:0] SR_CORE_TEST     = 8'd28;

  // Readback select codes
  localparam logic [4:0] RB_CORE_MISC   = 5'd1;
  localparam logic [4:0] RB_CORE_COMPAT = 5'd2;
  localparam logic [4:0] RB_CORE_PLL    = 5'd4;
  localparam logic [4:0] RB_CORE_TEST   = 5'd24;
  localparam logic [4:0] RB_DB0_STATUS  = 5'd16;
  localparam logic [4:0] RB_DB0_SPI     = 5'd17;
  localparam logic [4:0] RB_DB1_STATUS  = 5'd20;
  localparam logic [4:0] RB_DB1_SPI     = 5'd21;

  // Compatibility number reported to host software
  localparam logic [7:0]  COMPAT_MAJOR  = 8'hFF;
  localparam logic [7:0]  COMPAT_MINOR  = 8'h00;
  localparam logic [31:0] COMPAT_WORD   = {8'hAC, 8'h00, COMPAT_MAJOR, COMPAT_MINOR};

  // Internal PPS selected out of reset
  localparam logic [31:0] MISC_AT_RESET = 32'd2;
  localparam logic [31:0] RB_DEFAULT    = 32'hDEADBEEF;

endpackage

//--- hw/db_ctrl_pkg.sv
////////////////////////////////////////
// Daughterboard channel register map
// Offsets are added to a per-channel base
////////////////////////////////////////
package db_ctrl_pkg;

  // Channel base addresses on the settings bus
  localparam logic [7:0] DB0_BASE = 8'd160;
  localparam logic [7:0] DB1_BASE = 8'd176;

  // Register offsets within a channel
  localparam logic [1:0] DB_REG_GPIO     = 2'd0;
  localparam logic [1:0] DB_REG_FP       = 2'd1;
  localparam logic [1:0] DB_REG_SPI_DATA = 2'd2;
  localparam logic [1:0] DB_REG_SPI_CFG  = 2'd3;

  ////////////////////////////////////////
  // SPI config word layout
  ////////////////////////////////////////
  // Length of 1 to 32 in bits 5:0
  localparam int SPI_LEN_W = 6;
  // Half period minus one, starting at bit 8
  localparam int SPI_DIV_W   = 8;
  localparam int SPI_DIV_LSB = 8;

  // Zero or oversized lengths fall back to a full word
  localparam logic [SPI_LEN_W-1:0] SPI_MAX_LEN = 6'd32;

endpackage

//--- hw/setting_reg.sv
////////////////////////////////////////
// Payload comes from the low bits of the data word
// Payload wider than the bus is zero filled above
////////////////////////////////////////
`timescale 1ns/1ps

module setting_reg #(
  parameter logic [core_regs_pkg::SET_ADDR_W-1:0] ADDR = '0,
  parameter type T = logic [core_regs_pkg::SET_DATA_W-1:0],
  parameter T AT_RESET = '0
) (
  input  logic                                  bus_clk,
  input  logic                                  bus_rst,
  input  logic                                  i_set_stb,
  input  logic [core_regs_pkg::SET_ADDR_W-1:0]  i_set_addr,
  input  logic [core_regs_pkg::SET_DATA_W-1:0]  i_set_data,
  output T                                      o_value
);
  import core_regs_pkg::*;

  // Number of data bits that land in the payload
  localparam int LOAD_W = ($bits(T) < SET_DATA_W) ? $bits(T) : SET_DATA_W;

  logic hit;

  // Each register decodes its own address
  assign hit = i_set_stb && (i_set_addr == ADDR);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_value <= AT_RESET;
    end else if (hit) begin
      o_value <= T'(i_set_data[LOAD_W-1:0]);
    end
  end

endmodule

//--- hw/core_globals.sv
////////////////////////////////////////
// Readback word is combinational from the select register
// PLL lock shows up two cycles after it changes
////////////////////////////////////////
`timescale 1ns/1ps

module core_globals (
  input  logic                                  bus_clk,
  input  logic                                  bus_rst,
  input  logic                                  i_set_stb,
  input  logic [core_regs_pkg::SET_ADDR_W-1:0]  i_set_addr,
  input  logic [core_regs_pkg::SET_DATA_W-1:0]  i_set_data,
  input  logic [1:0]                            i_lock_signals,
  input  logic [3:0]                            i_tcxo_status,
  input  logic [31:0]                           i_db0_status,
  input  logic [31:0]                           i_db0_spi,
  input  logic [31:0]                           i_db1_status,
  input  logic [31:0]                           i_db1_spi,
  output logic [31:0]                           o_rb_data,
  output logic [1:0]                            o_pps_select,
  output logic                                  o_mimo,
  output logic                                  o_codec_arst
);
  import core_regs_pkg::*;

  logic [4:0]  rb_sel;
  logic [31:0] misc_q;
  logic [31:0] test_q;
  logic [1:0]  lock_meta_q;
  logic [1:0]  lock_sync_q;

  ////////////////////////////////////////
  // Global settings registers
  ////////////////////////////////////////
  setting_reg #(
    .ADDR     (SR_CORE_READBACK),
    .T        (logic [4:0]),
    .AT_RESET (5'd0)
  ) sr_readback (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_value    (rb_sel)
  );

  setting_reg #(
    .ADDR     (SR_CORE_MISC),
    .T        (logic [31:0]),
    .AT_RESET (MISC_AT_RESET)
  ) sr_misc (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_value    (misc_q)
  );

  // Scratch word for host bus tests
  setting_reg #(
    .ADDR     (SR_CORE_TEST),
    .T        (logic [31:0]),
    .AT_RESET (32'd0)
  ) sr_test (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_value    (test_q)
  );

  // Misc fields
  assign o_pps_select = misc_q[1:0];
  assign o_mimo       = misc_q[2];
  assign o_codec_arst = misc_q[3];

  // Two-stage lock synchronizer
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta_q <= 2'b00;
      lock_sync_q <= 2'b00;
    end else begin
      lock_meta_q <= i_lock_signals;
      lock_sync_q <= lock_meta_q;
    end
  end

  ////////////////////////////////////////
  // Readback mux
  ////////////////////////////////////////
  always_comb begin
    case (rb_sel)
      RB_CORE_MISC:   o_rb_data = {26'd0, i_tcxo_status, o_pps_select};
      RB_CORE_COMPAT: o_rb_data = COMPAT_WORD;
      RB_CORE_PLL:    o_rb_data = {30'd0, lock_sync_q};
      RB_CORE_TEST:   o_rb_data = test_q;
      RB_DB0_STATUS:  o_rb_data = i_db0_status;
      RB_DB0_SPI:     o_rb_data = i_db0_spi;
      RB_DB1_STATUS:  o_rb_data = i_db1_status;
      RB_DB1_SPI:     o_rb_data = i_db1_spi;
      default:        o_rb_data = RB_DEFAULT;
    endcase
  end

  // Select register must stay defined once out of reset
  assert property (@(posedge bus_clk) disable iff (bus_rst) !$isunknown(rb_sel));

endmodule

//--- hw/db_channel.sv
////////////////////////////////////////
// SPI mode 0, MSB first, length 1 to 32 bits
// Data writes while busy are dropped
////////////////////////////////////////
`timescale 1ns/1ps

module db_channel #(
  parameter logic [core_regs_pkg::SET_ADDR_W-1:0] BASE = db_ctrl_pkg::DB0_BASE
) (
  input  logic                                  bus_clk,
  input  logic                                  bus_rst,
  input  logic                                  i_set_stb,
  input  logic [core_regs_pkg::SET_ADDR_W-1:0]  i_set_addr,
  input  logic [core_regs_pkg::SET_DATA_W-1:0]  i_set_data,
  input  logic [5:0]                            i_fp_gpio_in,
  input  logic                                  i_spi_gnt,
  input  logic                                  i_miso,
  output logic [31:0]                           o_db_gpio,
  output logic [5:0]                            o_fp_gpio_out,
  output logic [5:0]                            o_fp_gpio_ddr,
  output logic [2:0]                            o_leds,
  output logic                                  o_spi_req,
  output logic                                  o_sen,
  output logic                                  o_sclk,
  output logic                                  o_mosi,
  output logic [31:0]                           o_status,
  output logic [31:0]                           o_spi_rdata
);
  import db_ctrl_pkg::*;

  localparam logic [7:0] SR_GPIO     = BASE + {6'd0, DB_REG_GPIO};
  localparam logic [7:0] SR_FP       = BASE + {6'd0, DB_REG_FP};
  localparam logic [7:0] SR_SPI_DATA = BASE + {6'd0, DB_REG_SPI_DATA};
  localparam logic [7:0] SR_SPI_CFG  = BASE + {6'd0, DB_REG_SPI_CFG};

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT_GNT, ST_XFER} spi_state_t;

  logic [18:0]           fp_q;
  logic                  cfg_hit;
  logic                  data_hit;
  logic [SPI_LEN_W-1:0]  cfg_len_q;
  logic [SPI_DIV_W-1:0]  cfg_div_q;
  logic [SPI_LEN_W-1:0]  len_eff;
  spi_state_t            state_q;
  logic                  busy;
  logic [SPI_DIV_W-1:0]  div_q;
  logic [SPI_DIV_W-1:0]  half_cnt_q;
  logic [SPI_LEN_W-1:0]  bit_cnt_q;
  logic [31:0]           shift_q;
  logic [31:0]           rx_q;

  ////////////////////////////////////////
  // GPIO and front panel
  ////////////////////////////////////////
  setting_reg #(
    .ADDR     (SR_GPIO),
    .T        (logic [31:0]),
    .AT_RESET (32'd0)
  ) sr_gpio (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_value    (o_db_gpio)
  );

  setting_reg #(
    .ADDR     (SR_FP),
    .T        (logic [18:0]),
    .AT_RESET (19'd0)
  ) sr_fp (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .o_value    (fp_q)
  );

  assign o_fp_gpio_out = fp_q[5:0];
  assign o_fp_gpio_ddr = fp_q[13:8];
  assign o_leds        = fp_q[18:16];

  ////////////////////////////////////////
  // SPI shift engine
  ////////////////////////////////////////
  assign cfg_hit  = i_set_stb && (i_set_addr == SR_SPI_CFG);
  assign data_hit = i_set_stb && (i_set_addr == SR_SPI_DATA);
  assign len_eff  = (cfg_len_q == '0 || cfg_len_q > SPI_MAX_LEN) ? SPI_MAX_LEN : cfg_len_q;
  assign busy     = (state_q != ST_IDLE);

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      cfg_len_q <= SPI_MAX_LEN;
      cfg_div_q <= '0;
      state_q   <= ST_IDLE;
      o_sen     <= 1'b1;
      o_sclk    <= 1'b0;
    end else begin
      if (cfg_hit) begin
        cfg_len_q <= i_set_data[SPI_LEN_W-1:0];
        cfg_div_q <= i_set_data[SPI_DIV_LSB +: SPI_DIV_W];
      end
      case (state_q)
        ST_IDLE: begin
          if (data_hit) begin
            // First bit parked at bit 31
            shift_q   <= i_set_data << (SPI_MAX_LEN - len_eff);
            bit_cnt_q <= len_eff;
            div_q     <= cfg_div_q;
            rx_q      <= '0;
            state_q   <= ST_WAIT_GNT;
          end
        end
        ST_WAIT_GNT: begin
          if (i_spi_gnt) begin
            o_sen      <= 1'b0;
            half_cnt_q <= div_q;
            state_q    <= ST_XFER;
          end
        end
        ST_XFER: begin
          if (half_cnt_q != '0) begin
            half_cnt_q <= half_cnt_q - 1'b1;
          end else begin
            half_cnt_q <= div_q;
            if (!o_sclk) begin
              // Rising edge samples miso
              o_sclk <= 1'b1;
              rx_q   <= {rx_q[30:0], i_miso};
            end else begin
              o_sclk <= 1'b0;
              if (bit_cnt_q == 6'd1) begin
                o_sen   <= 1'b1;
                state_q <= ST_IDLE;
              end else begin
                bit_cnt_q <= bit_cnt_q - 1'b1;
                shift_q   <= shift_q << 1;
              end
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Line stays low whenever the channel does not own the bus
  assign o_mosi      = shift_q[31] & ~o_sen;
  assign o_spi_req   = busy;
  assign o_spi_rdata = rx_q;
  assign o_status    = {busy, 25'd0, i_fp_gpio_in};

  // Chip select only asserted under an arbiter grant
  assert property (@(posedge bus_clk) disable iff (bus_rst) !o_sen |-> i_spi_gnt);

endmodule

//--- hw/spi_bus_arbiter.sv
////////////////////////////////////////
// Channel 0 wins a tie; a grant holds until its request drops
// A waiting channel has no timeout
////////////////////////////////////////
`timescale 1ns/1ps

module spi_bus_arbiter (
  input  logic       bus_clk,
  input  logic       bus_rst,
  input  logic [1:0] i_req,
  input  logic [1:0] i_sen,
  input  logic [1:0] i_sclk,
  input  logic [1:0] i_mosi,
  output logic [1:0] o_gnt,
  output logic       o_spi_sen,
  output logic       o_spi_sclk,
  output logic       o_spi_mosi
);

  typedef enum logic [1:0] {ARB_IDLE, ARB_CH0, ARB_CH1} arb_state_t;

  arb_state_t state_q;

  // Grant FSM hands straight over when the other channel waits
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state_q <= ARB_IDLE;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (i_req[0]) begin
            state_q <= ARB_CH0;
          end else if (i_req[1]) begin
            state_q <= ARB_CH1;
          end
        end
        ARB_CH0: if (!i_req[0]) state_q <= i_req[1] ? ARB_CH1 : ARB_IDLE;
        ARB_CH1: if (!i_req[1]) state_q <= i_req[0] ? ARB_CH0 : ARB_IDLE;
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  assign o_gnt = {state_q == ARB_CH1, state_q == ARB_CH0};

  // Shared bus merge
  assign o_spi_sen  = &i_sen;
  assign o_spi_sclk = |(i_sclk & o_gnt);
  assign o_spi_mosi = |(i_mosi & o_gnt);

  // Both channels selecting at once would corrupt the shared bus
  assert property (@(posedge bus_clk) disable iff (bus_rst) |i_sen);

endmodule

//--- hw/radio_ctrl_top.sv
////////////////////////////////////////
// Everything runs on bus_clk
// Both channels share one SPI bus through the arbiter
////////////////////////////////////////
`timescale 1ns/1ps

module radio_ctrl_top (
  input  logic                                  bus_clk,
  input  logic                                  bus_rst,
  input  logic                                  i_set_stb,
  input  logic [core_regs_pkg::SET_ADDR_W-1:0]  i_set_addr,
  input  logic [core_regs_pkg::SET_DATA_W-1:0]  i_set_data,
  input  logic [1:0]                            i_lock_signals,
  input  logic [3:0]                            i_tcxo_status,
  input  logic [5:0]                            i_fp_gpio_in0,
  input  logic [5:0]                            i_fp_gpio_in1,
  input  logic                                  i_spi_miso,
  output logic [31:0]                           o_rb_data,
  output logic [1:0]                            o_pps_select,
  output logic                                  o_mimo,
  output logic                                  o_codec_arst,
  output logic [31:0]                           o_db_gpio0,
  output logic [31:0]                           o_db_gpio1,
  output logic [5:0]                            o_fp_gpio_out0,
  output logic [5:0]                            o_fp_gpio_ddr0,
  output logic [5:0]                            o_fp_gpio_out1,
  output logic [5:0]                            o_fp_gpio_ddr1,
  output logic [2:0]                            o_leds0,
  output logic [2:0]                            o_leds1,
  output logic                                  o_spi_sen,
  output logic                                  o_spi_sclk,
  output logic                                  o_spi_mosi
);

  logic [31:0] db0_status;
  logic [31:0] db0_spi;
  logic [31:0] db1_status;
  logic [31:0] db1_spi;
  logic [1:0]  spi_req;
  logic [1:0]  spi_gnt;
  logic [1:0]  ch_sen;
  logic [1:0]  ch_sclk;
  logic [1:0]  ch_mosi;

  core_globals u_globals (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .i_lock_signals (i_lock_signals),
    .i_tcxo_status  (i_tcxo_status),
    .i_db0_status   (db0_status),
    .i_db0_spi      (db0_spi),
    .i_db1_status   (db1_status),
    .i_db1_spi      (db1_spi),
    .o_rb_data      (o_rb_data),
    .o_pps_select   (o_pps_select),
    .o_mimo         (o_mimo),
    .o_codec_arst   (o_codec_arst)
  );

  ////////////////////////////////////////
  // Daughterboard channels
  ////////////////////////////////////////
  db_channel #(.BASE(db_ctrl_pkg::DB0_BASE)) u_db0 (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_set_stb     (i_set_stb),
    .i_set_addr    (i_set_addr),
    .i_set_data    (i_set_data),
    .i_fp_gpio_in  (i_fp_gpio_in0),
    .i_spi_gnt     (spi_gnt[0]),
    .i_miso        (i_spi_miso),
    .o_db_gpio     (o_db_gpio0),
    .o_fp_gpio_out (o_fp_gpio_out0),
    .o_fp_gpio_ddr (o_fp_gpio_ddr0),
    .o_leds        (o_leds0),
    .o_spi_req     (spi_req[0]),
    .o_sen         (ch_sen[0]),
    .o_sclk        (ch_sclk[0]),
    .o_mosi        (ch_mosi[0]),
    .o_status      (db0_status),
    .o_spi_rdata   (db0_spi)
  );

  db_channel #(.BASE(db_ctrl_pkg::DB1_BASE)) u_db1 (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_set_stb     (i_set_stb),
    .i_set_addr    (i_set_addr),
    .i_set_data    (i_set_data),
    .i_fp_gpio_in  (i_fp_gpio_in1),
    .i_spi_gnt     (spi_gnt[1]),
    .i_miso        (i_spi_miso),
    .o_db_gpio     (o_db_gpio1),
    .o_fp_gpio_out (o_fp_gpio_out1),
    .o_fp_gpio_ddr (o_fp_gpio_ddr1),
    .o_leds        (o_leds1),
    .o_spi_req     (spi_req[1]),
    .o_sen         (ch_sen[1]),
    .o_sclk        (ch_sclk[1]),
    .o_mosi        (ch_mosi[1]),
    .o_status      (db1_status),
    .o_spi_rdata   (db1_spi)
  );

  // MISO fans out to both channels directly
  spi_bus_arbiter u_spi_arb (
    .bus_clk    (bus_clk),
    .bus_rst    (bus_rst),
    .i_req      (spi_req),
    .i_sen      (ch_sen),
    .i_sclk     (ch_sclk),
    .i_mosi     (ch_mosi),
    .o_gnt      (spi_gnt),
    .o_spi_sen  (o_spi_sen),
    .o_spi_sclk (o_spi_sclk),
    .o_spi_mosi (o_spi_mosi)
  );

endmodule

//--- verif/tb_radio_ctrl_top.sv
////////////////////////////////////////
// Directed tests for the bus-clock control core
// MISO is looped back from the shared MOSI line
////////////////////////////////////////
`timescale 1ns/1ps

module tb_radio_ctrl_top;
  import core_regs_pkg::*;
  import db_ctrl_pkg::*;

  localparam int CLK_PERIOD_NS = 20;
  localparam logic [31:0] LFSR_SEED = 32'h6df9;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;
  localparam logic [31:0] EXP_COMPAT = 32'hAC00FF00;
  localparam logic [31:0] EXP_DEFAULT = 32'hDEADBEEF;

  ////////////////////////////////////////
  // Cycle budgets
  ////////////////////////////////////////
  // Worst SPI case of 32 bits at a divider of 3 with grant and poll slack
  localparam int SPI_BUDGET = 32 * 2 * (3 + 1) + 16;
  // Reset, globals, lock and GPIO tests together
  localparam int BASIC_BUDGET = 200;
  localparam int TOTAL_CYCLES = BASIC_BUDGET + 3 * SPI_BUDGET;

  logic        bus_clk;
  logic        bus_rst;
  logic        i_set_stb;
  logic [7:0]  i_set_addr;
  logic [31:0] i_set_data;
  logic [1:0]  i_lock_signals;
  logic [3:0]  i_tcxo_status;
  logic [5:0]  i_fp_gpio_in0;
  logic [5:0]  i_fp_gpio_in1;
  logic        i_spi_miso;
  logic [31:0] o_rb_data;
  logic [1:0]  o_pps_select;
  logic        o_mimo;
  logic        o_codec_arst;
  logic [31:0] o_db_gpio0;
  logic [31:0] o_db_gpio1;
  logic [5:0]  o_fp_gpio_out0;
  logic [5:0]  o_fp_gpio_ddr0;
  logic [5:0]  o_fp_gpio_out1;
  logic [5:0]  o_fp_gpio_ddr1;
  logic [2:0]  o_leds0;
  logic [2:0]  o_leds1;
  logic        o_spi_sen;
  logic        o_spi_sclk;
  logic        o_spi_mosi;

  logic [31:0] lfsr_q;
  logic [31:0] exp_gpio [2];
  logic [18:0] exp_fp [2];
  logic        arb_watch;
  int          sen_overlap;
  int          shared_sen_low;
  int          sclk_rises;
  logic        sclk_prev;

  // Loopback so each channel receives what it sends
  assign i_spi_miso = o_spi_mosi;

  radio_ctrl_top i_dut (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .i_set_stb      (i_set_stb),
    .i_set_addr     (i_set_addr),
    .i_set_data     (i_set_data),
    .i_lock_signals (i_lock_signals),
    .i_tcxo_status  (i_tcxo_status),
    .i_fp_gpio_in0  (i_fp_gpio_in0),
    .i_fp_gpio_in1  (i_fp_gpio_in1),
    .i_spi_miso     (i_spi_miso),
    .o_rb_data      (o_rb_data),
    .o_pps_select   (o_pps_select),
    .o_mimo         (o_mimo),
    .o_codec_arst   (o_codec_arst),
    .o_db_gpio0     (o_db_gpio0),
    .o_db_gpio1     (o_db_gpio1),
    .o_fp_gpio_out0 (o_fp_gpio_out0),
    .o_fp_gpio_ddr0 (o_fp_gpio_ddr0),
    .o_fp_gpio_out1 (o_fp_gpio_out1),
    .o_fp_gpio_ddr1 (o_fp_gpio_ddr1),
    .o_leds0        (o_leds0),
    .o_leds1        (o_leds1),
    .o_spi_sen      (o_spi_sen),
    .o_spi_sclk     (o_spi_sclk),
    .o_spi_mosi     (o_spi_mosi)
  );

  initial begin
    bus_clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) bus_clk = ~bus_clk;
  end

  initial begin
    #(TOTAL_CYCLES * 2 * CLK_PERIOD_NS);
    stop_with_failure("Watchdog timeout, the tests ran past their cycle budget");
  end

  // Channel chip selects and shared clock watched mid-cycle during arbitration
  always @(negedge bus_clk) begin
    if (arb_watch) begin
      if (i_dut.ch_sen == 2'b00) sen_overlap++;
      if (!o_spi_sen) shared_sen_low++;
      if (o_spi_sclk && !sclk_prev) sclk_rises++;
    end
    sclk_prev = o_spi_sclk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch at time %0t: %s got 0x%08h expected 0x%08h",
                                  $time, name, got, exp));
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] len_mask(input logic [5:0] len);
    if (len >= 6'd32) return 32'hFFFFFFFF;
    return (32'd1 << len) - 32'd1;
  endfunction

  // Length in bits 5:0 and half period minus one in bits 15:8
  function automatic logic [31:0] cfg_word(input logic [5:0] len, input logic [7:0] div);
    return {16'd0, div, 2'b00, len};
  endfunction

  task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
    @(posedge bus_clk);
    #2;
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(posedge bus_clk);
    #2;
    i_set_stb = 1'b0;
  endtask

  task automatic write_back_to_back(input logic [7:0] addr0, input logic [31:0] data0,
                                    input logic [7:0] addr1, input logic [31:0] data1);
    @(posedge bus_clk);
    #2;
    i_set_stb  = 1'b1;
    i_set_addr = addr0;
    i_set_data = data0;
    @(posedge bus_clk);
    #2;
    i_set_addr = addr1;
    i_set_data = data1;
    @(posedge bus_clk);
    #2;
    i_set_stb = 1'b0;
  endtask

  task automatic read_back(input logic [4:0] code, output logic [31:0] value);
    write_setting(SR_CORE_READBACK, {27'd0, code});
    #1;
    value = o_rb_data;
  endtask

  task automatic verify_db_outputs();
    #1;
    expect_equal("o_db_gpio0", o_db_gpio0, exp_gpio[0]);
    expect_equal("o_db_gpio1", o_db_gpio1, exp_gpio[1]);
    expect_equal("o_fp_gpio_out0", 32'(o_fp_gpio_out0), 32'(exp_fp[0][5:0]));
    expect_equal("o_fp_gpio_ddr0", 32'(o_fp_gpio_ddr0), 32'(exp_fp[0][13:8]));
    expect_equal("o_leds0", 32'(o_leds0), 32'(exp_fp[0][18:16]));
    expect_equal("o_fp_gpio_out1", 32'(o_fp_gpio_out1), 32'(exp_fp[1][5:0]));
    expect_equal("o_fp_gpio_ddr1", 32'(o_fp_gpio_ddr1), 32'(exp_fp[1][13:8]));
    expect_equal("o_leds1", 32'(o_leds1), 32'(exp_fp[1][18:16]));
  endtask

  // Polls the channel status until busy clears
  task automatic wait_spi_idle(input int ch, input bit expect_busy);
    logic [31:0] rb;
    int          waited;
    read_back((ch == 0) ? RB_DB0_STATUS : RB_DB1_STATUS, rb);
    if (expect_busy) begin
      expect_equal("status busy after data write", 32'(rb[31]), 32'd1);
    end
    waited = 0;
    while (rb[31] === 1'b1 && waited < SPI_BUDGET) begin
      @(posedge bus_clk);
      #1;
      rb = o_rb_data;
      waited++;
    end
    if (rb[31] !== 1'b0) begin
      stop_with_failure($sformatf("SPI transfer on channel %0d did not finish in %0d cycles",
                                  ch, SPI_BUDGET));
    end
  endtask

  task automatic step_lock(input logic [1:0] new_val, input logic [1:0] old_val);
    @(posedge bus_clk);
    #2;
    i_lock_signals = new_val;
    @(posedge bus_clk);
    #1;
    expect_equal("pll readback one cycle after change", o_rb_data, 32'(old_val));
    @(posedge bus_clk);
    #1;
    expect_equal("pll readback two cycles after change", o_rb_data, 32'(new_val));
    @(posedge bus_clk);
    #1;
    expect_equal("pll readback three cycles after change", o_rb_data, 32'(new_val));
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic reset_values();
    logic [31:0] rb;
    #1;
    expect_equal("o_pps_select", 32'(o_pps_select), 32'd2);
    expect_equal("o_mimo", 32'(o_mimo), 32'd0);
    expect_equal("o_codec_arst", 32'(o_codec_arst), 32'd0);
    expect_equal("o_spi_sen", 32'(o_spi_sen), 32'd1);
    expect_equal("o_spi_sclk", 32'(o_spi_sclk), 32'd0);
    expect_equal("o_spi_mosi", 32'(o_spi_mosi), 32'd0);
    verify_db_outputs();
    read_back(RB_CORE_COMPAT, rb);
    expect_equal("compat readback", rb, EXP_COMPAT);
    read_back(5'd31, rb);
    expect_equal("unused code readback", rb, EXP_DEFAULT);
  endtask

  task automatic global_regs();
    logic [31:0] word;
    logic [31:0] rb;
    logic [3:0]  tcxo;
    word = rand_bits(32);
    write_setting(SR_CORE_TEST, word);
    read_back(RB_CORE_TEST, rb);
    expect_equal("test word readback", rb, word);
    // pps_select 1, mimo and codec reset set
    write_setting(SR_CORE_MISC, 32'h0000000D);
    #1;
    expect_equal("o_pps_select", 32'(o_pps_select), 32'd1);
    expect_equal("o_mimo", 32'(o_mimo), 32'd1);
    expect_equal("o_codec_arst", 32'(o_codec_arst), 32'd1);
    tcxo = 4'(rand_bits(4));
    @(posedge bus_clk);
    #2;
    i_tcxo_status = tcxo;
    read_back(RB_CORE_MISC, rb);
    expect_equal("misc readback", rb, {26'd0, tcxo, 2'b01});
    write_setting(SR_CORE_MISC, 32'h00000002);
    #1;
    expect_equal("o_pps_select", 32'(o_pps_select), 32'd2);
    expect_equal("o_mimo", 32'(o_mimo), 32'd0);
    expect_equal("o_codec_arst", 32'(o_codec_arst), 32'd0);
  endtask

  task automatic lock_synchronizer();
    logic [31:0] rb;
    read_back(RB_CORE_PLL, rb);
    expect_equal("pll readback at rest", rb, 32'd0);
    step_lock(2'b11, 2'b00);
    step_lock(2'b01, 2'b11);
  endtask

  task automatic channel_gpio();
    logic [7:0]  base;
    logic [5:0]  fp_in0;
    logic [5:0]  fp_in1;
    logic [31:0] rb;
    int          ch;
    for (ch = 0; ch < 2; ch++) begin
      base = (ch == 0) ? DB0_BASE : DB1_BASE;
      exp_gpio[ch] = rand_bits(32);
      write_setting(base + 8'(DB_REG_GPIO), exp_gpio[ch]);
      verify_db_outputs();
      exp_fp[ch] = 19'(rand_bits(19));
      write_setting(base + 8'(DB_REG_FP), 32'(exp_fp[ch]));
      verify_db_outputs();
    end
    fp_in0 = 6'(rand_bits(6));
    fp_in1 = 6'(rand_bits(6));
    @(posedge bus_clk);
    #2;
    i_fp_gpio_in0 = fp_in0;
    i_fp_gpio_in1 = fp_in1;
    read_back(RB_DB0_STATUS, rb);
    expect_equal("db0 status readback", rb, {26'd0, fp_in0});
    read_back(RB_DB1_STATUS, rb);
    expect_equal("db1 status readback", rb, {26'd0, fp_in1});
  endtask

  task automatic single_spi_transfer();
    logic [5:0]  len;
    logic [7:0]  div;
    logic [31:0] word;
    logic [31:0] rb;
    len  = 6'(rand_bits(5)) + 6'd1;
    div  = 8'(rand_bits(2));
    word = rand_bits(32);
    write_setting(DB0_BASE + 8'(DB_REG_SPI_CFG), cfg_word(len, div));
    write_setting(DB0_BASE + 8'(DB_REG_SPI_DATA), word);
    // Dropped while the channel is busy
    write_setting(DB0_BASE + 8'(DB_REG_SPI_DATA), ~word);
    wait_spi_idle(0, 1'b1);
    read_back(RB_DB0_SPI, rb);
    expect_equal("db0 spi readback", rb, word & len_mask(len));
    expect_equal("o_spi_sen after transfer", 32'(o_spi_sen), 32'd1);
    expect_equal("o_spi_sclk after transfer", 32'(o_spi_sclk), 32'd0);
  endtask

  task automatic spi_arbitration();
    logic [5:0]  len0;
    logic [5:0]  len1;
    logic [7:0]  div0;
    logic [7:0]  div1;
    logic [31:0] word0;
    logic [31:0] word1;
    logic [31:0] rb;
    len0  = 6'(rand_bits(5)) + 6'd1;
    div0  = 8'(rand_bits(2));
    word0 = rand_bits(32);
    len1  = 6'(rand_bits(5)) + 6'd1;
    div1  = 8'(rand_bits(2));
    word1 = rand_bits(32);
    write_setting(DB0_BASE + 8'(DB_REG_SPI_CFG), cfg_word(len0, div0));
    write_setting(DB1_BASE + 8'(DB_REG_SPI_CFG), cfg_word(len1, div1));
    sen_overlap    = 0;
    shared_sen_low = 0;
    sclk_rises     = 0;
    arb_watch      = 1'b1;
    write_back_to_back(DB0_BASE + 8'(DB_REG_SPI_DATA), word0,
                       DB1_BASE + 8'(DB_REG_SPI_DATA), word1);
    wait_spi_idle(0, 1'b1);
    wait_spi_idle(1, 1'b0);
    arb_watch = 1'b0;
    expect_equal("cycles with both channel sens low", 32'(sen_overlap), 32'd0);
    expect_equal("shared sen seen low", 32'(shared_sen_low != 0), 32'd1);
    expect_equal("shared sclk rising edges", 32'(sclk_rises), 32'(len0) + 32'(len1));
    read_back(RB_DB0_SPI, rb);
    expect_equal("db0 spi readback", rb, word0 & len_mask(len0));
    read_back(RB_DB1_SPI, rb);
    expect_equal("db1 spi readback", rb, word1 & len_mask(len1));
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    lfsr_q         = LFSR_SEED;
    bus_rst        = 1'b1;
    i_set_stb      = 1'b0;
    i_set_addr     = 8'd0;
    i_set_data     = 32'd0;
    i_lock_signals = 2'b00;
    i_tcxo_status  = 4'd0;
    i_fp_gpio_in0  = 6'd0;
    i_fp_gpio_in1  = 6'd0;
    exp_gpio[0]    = 32'd0;
    exp_gpio[1]    = 32'd0;
    exp_fp[0]      = 19'd0;
    exp_fp[1]      = 19'd0;
    arb_watch      = 1'b0;
    sen_overlap    = 0;
    shared_sen_low = 0;
    sclk_rises     = 0;
    sclk_prev      = 1'b0;
    repeat (4) @(posedge bus_clk);
    #2;
    bus_rst = 1'b0;
    reset_values();
    global_regs();
    lock_synchronizer();
    channel_gpio();
    single_spi_transfer();
    spi_arbitration();
    $display("All checks passed");
    $finish;
  end

endmodule

//--- project.f
hw/core_regs_pkg.sv
hw/db_ctrl_pkg.sv
hw/setting_reg.sv
hw/core_globals.sv
hw/db_channel.sv
hw/spi_bus_arbiter.sv
hw/radio_ctrl_top.sv
verif/tb_radio_ctrl_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_radio_ctrl_top -f project.f \
  && { ./obj_dir/Vtb_radio_ctrl_top > sim.log 2>&1; cat sim.log; }

grep -q "All checks passed" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
